// File: videoPkg.sv
`default_nettype none

package videoPkg;

	// ---------------------------------------------------------------------
	// Widths and sizes
	// ---------------------------------------------------------------------
	// Horizontal and vertical counters and timing registers
	localparam int hWidth = 11;
	localparam int vWidth = 11;
	// Map chip edge as a shift, 4 gives 16x16 tiles
	localparam int mapChipBs = 4;
	// Pixel FIFO
	localparam int fifoDepth = 32;
	localparam int fifoAddrWidth = $clog2(fifoDepth);
	// APB bus
	localparam int apbAddrWidth = 6;
	localparam int apbDataWidth = 16;

	// ---------------------------------------------------------------------
	// Types
	// ---------------------------------------------------------------------
	// RGB444, alpha nibble is not carried
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} pixelT;

	typedef struct packed {
		logic [apbAddrWidth-1:0] paddr;
		logic                    psel;
		logic                    penable;
		logic                    pwrite;
		logic [apbDataWidth-1:0] pwdata;
	} apbReqT;

	// Display timing, all counts start at zero
	typedef struct packed {
		logic [hWidth-1:0] hDisplay;
		logic [hWidth-1:0] hSyncStart;
		logic [hWidth-1:0] hSyncEnd;
		logic [hWidth-1:0] hMax;
		logic [vWidth-1:0] vDisplay;
		logic [vWidth-1:0] vSyncStart;
		logic [vWidth-1:0] vSyncEnd;
		logic [vWidth-1:0] vMax;
	} displayCfgT;

	// ---------------------------------------------------------------------
	// Register map, word addresses
	// ---------------------------------------------------------------------
	localparam logic [apbAddrWidth-1:0] regHDisplay   = 6'd0;
	localparam logic [apbAddrWidth-1:0] regHSyncStart = 6'd1;
	localparam logic [apbAddrWidth-1:0] regHSyncEnd   = 6'd2;
	localparam logic [apbAddrWidth-1:0] regHMax       = 6'd3;
	localparam logic [apbAddrWidth-1:0] regVDisplay   = 6'd4;
	localparam logic [apbAddrWidth-1:0] regVSyncStart = 6'd5;
	localparam logic [apbAddrWidth-1:0] regVSyncEnd   = 6'd6;
	localparam logic [apbAddrWidth-1:0] regVMax       = 6'd7;
	localparam logic [apbAddrWidth-1:0] regColorA     = 6'd8;
	localparam logic [apbAddrWidth-1:0] regColorB     = 6'd9;
	localparam logic [apbAddrWidth-1:0] regBlDuty     = 6'd10;
	// Bit 0 videoEn
	localparam logic [apbAddrWidth-1:0] regCtrl       = 6'd11;
	// Bit 0 sticky underrun, bits 15:8 frame count
	localparam logic [apbAddrWidth-1:0] regStatus     = 6'd12;

endpackage

`default_nettype wire

// File: videoCsrApb.sv
`timescale 1ns/1ps
`default_nettype none

module videoCsrApb (
	input  wire                                sClk,
	input  wire                                rstN,
	input  wire videoPkg::apbReqT              apbReq,
	output logic [videoPkg::apbDataWidth-1:0]  prdata,
	output videoPkg::displayCfgT               displayCfg,
	output videoPkg::pixelT                    colorA,
	output videoPkg::pixelT                    colorB,
	output logic [7:0]                         blDuty,
	output logic                               videoEn,
	input  wire                                frameDone,
	input  wire                                underrun
);
	import videoPkg::*;

	logic       wrAcc;
	logic       enRise;
	logic       underrunFlag;
	logic [7:0] frameCount;

	// Write lands at the end of the access phase
	assign wrAcc = apbReq.psel & apbReq.penable & apbReq.pwrite;
	// Enable going 0 to 1 restarts the status
	assign enRise = wrAcc & (apbReq.paddr == regCtrl) & apbReq.pwdata[0] & ~videoEn;

	// ---------------------------------------------------------------------
	// Configuration registers
	// ---------------------------------------------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			displayCfg <= '0;
			colorA     <= '0;
			colorB     <= '0;
			blDuty     <= '0;
			videoEn    <= 1'b0;
		end
		else if (wrAcc)
		begin
			case (apbReq.paddr)
				regHDisplay:   displayCfg.hDisplay   <= apbReq.pwdata[hWidth-1:0];
				regHSyncStart: displayCfg.hSyncStart <= apbReq.pwdata[hWidth-1:0];
				regHSyncEnd:   displayCfg.hSyncEnd   <= apbReq.pwdata[hWidth-1:0];
				regHMax:       displayCfg.hMax       <= apbReq.pwdata[hWidth-1:0];
				regVDisplay:   displayCfg.vDisplay   <= apbReq.pwdata[vWidth-1:0];
				regVSyncStart: displayCfg.vSyncStart <= apbReq.pwdata[vWidth-1:0];
				regVSyncEnd:   displayCfg.vSyncEnd   <= apbReq.pwdata[vWidth-1:0];
				regVMax:       displayCfg.vMax       <= apbReq.pwdata[vWidth-1:0];
				regColorA:     colorA                <= apbReq.pwdata[$bits(pixelT)-1:0];
				regColorB:     colorB                <= apbReq.pwdata[$bits(pixelT)-1:0];
				regBlDuty:     blDuty                <= apbReq.pwdata[7:0];
				regCtrl:       videoEn               <= apbReq.pwdata[0];
				default:       ;
			endcase
		end
	end

	// ---------------------------------------------------------------------
	// Status, frame count wraps at 8 bits
	// ---------------------------------------------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			underrunFlag <= 1'b0;
			frameCount   <= '0;
		end
		else if (enRise)
		begin
			underrunFlag <= 1'b0;
			frameCount   <= '0;
		end
		else
		begin
			// Sticky until the next enable
			if (underrun)
				underrunFlag <= 1'b1;
			if (frameDone)
				frameCount <= frameCount + 8'd1;
		end
	end

	// Read mux, unmapped words give zero
	always_comb
	begin
		case (apbReq.paddr)
			regHDisplay:   prdata = apbDataWidth'(displayCfg.hDisplay);
			regHSyncStart: prdata = apbDataWidth'(displayCfg.hSyncStart);
			regHSyncEnd:   prdata = apbDataWidth'(displayCfg.hSyncEnd);
			regHMax:       prdata = apbDataWidth'(displayCfg.hMax);
			regVDisplay:   prdata = apbDataWidth'(displayCfg.vDisplay);
			regVSyncStart: prdata = apbDataWidth'(displayCfg.vSyncStart);
			regVSyncEnd:   prdata = apbDataWidth'(displayCfg.vSyncEnd);
			regVMax:       prdata = apbDataWidth'(displayCfg.vMax);
			regColorA:     prdata = apbDataWidth'(colorA);
			regColorB:     prdata = apbDataWidth'(colorB);
			regBlDuty:     prdata = apbDataWidth'(blDuty);
			regCtrl:       prdata = apbDataWidth'(videoEn);
			regStatus:     prdata = {frameCount, 7'd0, underrunFlag};
			default:       prdata = '0;
		endcase
	end

	// Access phase only ever follows a select from the master
	penableWithPsel: assert property (@(posedge sClk) disable iff (!rstN)
		apbReq.penable |-> apbReq.psel);

endmodule

`default_nettype wire

// File: videoPixelGen.sv
`timescale 1ns/1ps
`default_nettype none

module videoPixelGen (
	input  wire                       sClk,
	input  wire                       rstN,
	input  wire                       videoEn,
	input  wire videoPkg::displayCfgT displayCfg,
	input  wire videoPkg::pixelT      colorA,
	input  wire videoPkg::pixelT      colorB,
	input  wire                       full,
	output logic                      wrEn,
	output videoPkg::pixelT           wrPixel
);
	import videoPkg::*;

	logic [hWidth-1:0] x;
	logic [vWidth-1:0] y;
	logic              lineEnd;
	logic              frameEnd;

	// One pixel per cycle unless the FIFO pushes back
	assign wrEn     = videoEn & ~full;
	assign lineEnd  = (x == displayCfg.hDisplay - hWidth'(1));
	assign frameEnd = (y == displayCfg.vDisplay - vWidth'(1));

	// ---------------------------------------------------------------------
	// Raster position, moves on accepted writes only
	// ---------------------------------------------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			x <= '0;
			y <= '0;
		end
		else if (!videoEn)
		begin
			// Parked at the origin while off
			x <= '0;
			y <= '0;
		end
		else if (wrEn)
		begin
			if (lineEnd)
			begin
				x <= '0;
				y <= frameEnd ? '0 : y + vWidth'(1);
			end
			else
				x <= x + hWidth'(1);
		end
	end

	// Checkerboard, origin tile in colorA
	assign wrPixel = (x[mapChipBs] ^ y[mapChipBs]) ? colorB : colorA;

endmodule

`default_nettype wire

// File: videoDualClkFifo.sv
`timescale 1ns/1ps
`default_nettype none

module videoDualClkFifo (
	input  wire                  wrClk,
	input  wire                  rdClk,
	input  wire                  rstN,
	input  wire                  wrEn,
	input  wire videoPkg::pixelT wrData,
	output logic                 full,
	input  wire                  rdEn,
	output videoPkg::pixelT      rdData,
	output logic                 empty
);
	import videoPkg::*;

	// Pointers carry a wrap bit above the address
	logic [fifoAddrWidth:0] wrBin;
	logic [fifoAddrWidth:0] wrBinNext;
	logic [fifoAddrWidth:0] wrGray;
	logic [fifoAddrWidth:0] rdBin;
	logic [fifoAddrWidth:0] rdBinNext;
	logic [fifoAddrWidth:0] rdGray;
	logic [fifoAddrWidth:0] rdGraySync1;
	logic [fifoAddrWidth:0] rdGraySync2;
	logic [fifoAddrWidth:0] wrGraySync1;
	logic [fifoAddrWidth:0] wrGraySync2;
	logic                   wrAcc;
	logic                   rdAcc;
	pixelT                  mem [fifoDepth];

	assign wrAcc     = wrEn & ~full;
	assign rdAcc     = rdEn & ~empty;
	assign wrBinNext = wrBin + 1'b1;
	assign rdBinNext = rdBin + 1'b1;

	// ---------------------------------------------------------------------
	// Write side
	// ---------------------------------------------------------------------
	always_ff @(posedge wrClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrBin       <= '0;
			wrGray      <= '0;
			rdGraySync1 <= '0;
			rdGraySync2 <= '0;
		end
		else
		begin
			// Two flops for the read pointer
			rdGraySync1 <= rdGray;
			rdGraySync2 <= rdGraySync1;
			if (wrAcc)
			begin
				wrBin  <= wrBinNext;
				wrGray <= wrBinNext ^ (wrBinNext >> 1);
			end
		end
	end

	always_ff @(posedge wrClk)
	begin
		if (wrAcc)
			mem[wrBin[fifoAddrWidth-1:0]] <= wrData;
	end

	// Full when the top two gray bits differ and the rest match
	assign full = (wrGray == {~rdGraySync2[fifoAddrWidth:fifoAddrWidth-1],
		rdGraySync2[fifoAddrWidth-2:0]});

	// ---------------------------------------------------------------------
	// Read side
	// ---------------------------------------------------------------------
	always_ff @(posedge rdClk or negedge rstN)
	begin
		if (!rstN)
		begin
			rdBin       <= '0;
			rdGray      <= '0;
			wrGraySync1 <= '0;
			wrGraySync2 <= '0;
			rdData      <= '0;
		end
		else
		begin
			wrGraySync1 <= wrGray;
			wrGraySync2 <= wrGraySync1;
			// Empty read keeps the last pixel
			if (rdAcc)
			begin
				rdData <= mem[rdBin[fifoAddrWidth-1:0]];
				rdBin  <= rdBinNext;
				rdGray <= rdBinNext ^ (rdBinNext >> 1);
			end
		end
	end

	assign empty = (rdGray == wrGraySync2);

	// Accepted write never lands on an entry the reader still owns
	noWriteWhenFull: assert property (@(posedge wrClk) disable iff (!rstN)
		wrAcc |-> ((fifoAddrWidth+1)'(wrBin - rdBin) < fifoDepth));

endmodule

`default_nettype wire

// File: videoSyncGen.sv
`timescale 1ns/1ps
`default_nettype none

module videoSyncGen (
	input  wire                       videoClk,
	input  wire                       sClk,
	input  wire                       rstN,
	input  wire                       videoEn,
	input  wire videoPkg::displayCfgT displayCfg,
	input  wire                       fifoEmpty,
	output logic                      fifoRdEn,
	output logic                      hSync,
	output logic                      vSync,
	output logic                      de,
	output logic                      frameDone,
	output logic                      underrun
);
	import videoPkg::*;

	logic              enMeta;
	logic              enSync;
	logic [hWidth-1:0] hCount;
	logic [vWidth-1:0] vCount;
	logic              lineEnd;
	logic              frameEnd;
	logic              frameTgl;
	logic              underrunTgl;
	logic [2:0]        frameSync;
	logic [2:0]        underrunSync;

	assign lineEnd  = (hCount == displayCfg.hMax - hWidth'(1));
	assign frameEnd = lineEnd & (vCount == displayCfg.vMax - vWidth'(1));

	// ---------------------------------------------------------------------
	// Enable sync and raster counters
	// ---------------------------------------------------------------------
	always_ff @(posedge videoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			enMeta <= 1'b0;
			enSync <= 1'b0;
			hCount <= '0;
			vCount <= '0;
		end
		else
		begin
			enMeta <= videoEn;
			enSync <= enMeta;
			if (!enSync)
			begin
				// Start inside vertical blanking so the FIFO can fill
				hCount <= '0;
				vCount <= displayCfg.vDisplay;
			end
			else if (lineEnd)
			begin
				hCount <= '0;
				vCount <= frameEnd ? '0 : vCount + vWidth'(1);
			end
			else
				hCount <= hCount + hWidth'(1);
		end
	end

	// Registered sync and data enable
	always_ff @(posedge videoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hSync       <= 1'b0;
			vSync       <= 1'b0;
			de          <= 1'b0;
			frameTgl    <= 1'b0;
			underrunTgl <= 1'b0;
		end
		else
		begin
			hSync <= enSync & (hCount >= displayCfg.hSyncStart) & (hCount < displayCfg.hSyncEnd);
			vSync <= enSync & (vCount >= displayCfg.vSyncStart) & (vCount < displayCfg.vSyncEnd);
			de    <= enSync & (hCount < displayCfg.hDisplay) & (vCount < displayCfg.vDisplay);
			// Events become toggles for the sClk side
			if (enSync & frameEnd)
				frameTgl <= ~frameTgl;
			if (de & fifoEmpty)
				underrunTgl <= ~underrunTgl;
		end
	end

	// Pop on data enable, drain leftovers while off
	assign fifoRdEn = de | (~enSync & ~fifoEmpty);

	// ---------------------------------------------------------------------
	// Toggle synchronizers into sClk
	// ---------------------------------------------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			frameSync    <= '0;
			underrunSync <= '0;
		end
		else
		begin
			frameSync    <= {frameSync[1:0], frameTgl};
			underrunSync <= {underrunSync[1:0], underrunTgl};
		end
	end

	assign frameDone = frameSync[2] ^ frameSync[1];
	assign underrun  = underrunSync[2] ^ underrunSync[1];

	// Horizontal sync window sits inside the line once running
	hSyncWindow: assert property (@(posedge videoClk) disable iff (!rstN)
		enSync |-> (displayCfg.hSyncStart < displayCfg.hSyncEnd) &&
			(displayCfg.hSyncEnd <= displayCfg.hMax));

endmodule

`default_nettype wire

// File: dutyGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module dutyGenerator (
	input  wire       sClk,
	input  wire       rstN,
	input  wire [7:0] duty,
	output logic      pwm
);

	// Free-running period of 256 cycles
	logic [7:0] count;

	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			count <= '0;
			pwm   <= 1'b0;
		end
		else
		begin
			count <= count + 8'd1;
			// High for duty counts of each period
			pwm   <= (count < duty);
		end
	end

endmodule

`default_nettype wire

// File: videoTxUnit.sv
`timescale 1ns/1ps
`default_nettype none

module videoTxUnit (
	input  wire                               sClk,
	input  wire                               videoClk,
	input  wire                               rstN,
	input  wire videoPkg::apbReqT             apbReq,
	output logic [videoPkg::apbDataWidth-1:0] prdata,
	output videoPkg::pixelT                   tftColor,
	output logic                              tftHSync,
	output logic                              tftVSync,
	output logic                              tftDe,
	output logic                              tftBackLight
);
	import videoPkg::*;

	displayCfgT displayCfg;
	pixelT      colorA;
	pixelT      colorB;
	logic [7:0] blDuty;
	logic       videoEn;
	logic       frameDone;
	logic       underrun;
	logic       wrEn;
	pixelT      wrPixel;
	logic       fifoFull;
	logic       fifoRdEn;
	pixelT      fifoRdData;
	logic       fifoEmpty;
	logic       hSync;
	logic       vSync;
	logic       de;

	// ---------------------------------------------------------------------
	// Registers and backlight, sClk
	// ---------------------------------------------------------------------
	videoCsrApb csr (
		.sClk       (sClk),
		.rstN       (rstN),
		.apbReq     (apbReq),
		.prdata     (prdata),
		.displayCfg (displayCfg),
		.colorA     (colorA),
		.colorB     (colorB),
		.blDuty     (blDuty),
		.videoEn    (videoEn),
		.frameDone  (frameDone),
		.underrun   (underrun)
	);

	dutyGenerator backLight (
		.sClk (sClk),
		.rstN (rstN),
		.duty (blDuty),
		.pwm  (tftBackLight)
	);

	// ---------------------------------------------------------------------
	// Pixel path, sClk into videoClk
	// ---------------------------------------------------------------------
	videoPixelGen pixelGen (
		.sClk       (sClk),
		.rstN       (rstN),
		.videoEn    (videoEn),
		.displayCfg (displayCfg),
		.colorA     (colorA),
		.colorB     (colorB),
		.full       (fifoFull),
		.wrEn       (wrEn),
		.wrPixel    (wrPixel)
	);

	videoDualClkFifo pixelFifo (
		.wrClk  (sClk),
		.rdClk  (videoClk),
		.rstN   (rstN),
		.wrEn   (wrEn),
		.wrData (wrPixel),
		.full   (fifoFull),
		.rdEn   (fifoRdEn),
		.rdData (fifoRdData),
		.empty  (fifoEmpty)
	);

	// Config is quasi-static, only videoEn gets synchronized
	videoSyncGen syncGen (
		.videoClk   (videoClk),
		.sClk       (sClk),
		.rstN       (rstN),
		.videoEn    (videoEn),
		.displayCfg (displayCfg),
		.fifoEmpty  (fifoEmpty),
		.fifoRdEn   (fifoRdEn),
		.hSync      (hSync),
		.vSync      (vSync),
		.de         (de),
		.frameDone  (frameDone),
		.underrun   (underrun)
	);

	// ---------------------------------------------------------------------
	// Display outputs
	// ---------------------------------------------------------------------
	// Syncs wait one cycle for the FIFO read register
	always_ff @(posedge videoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			tftHSync <= 1'b0;
			tftVSync <= 1'b0;
			tftDe    <= 1'b0;
		end
		else
		begin
			tftHSync <= hSync;
			tftVSync <= vSync;
			tftDe    <= de;
		end
	end

	// Color blanked outside the active area
	assign tftColor = tftDe ? fifoRdData : '0;

endmodule

`default_nettype wire

// File: tbVideoTxUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tbVideoTxUnit;
	import videoPkg::*;

	localparam int numRows = 3;
	localparam int sClkHalf = 4;
	localparam int videoClkHalf = 10;
	localparam int pixelBits = $bits(pixelT);

	// One table row, colors are replaced when randColors is set
	typedef struct packed {
		displayCfgT cfg;
		pixelT      colorA;
		pixelT      colorB;
		logic [7:0] blDuty;
		logic       randColors;
	} rowT;

	logic                    sClk;
	logic                    videoClk;
	logic                    rstN;
	apbReqT                  apbReq;
	logic [apbDataWidth-1:0] prdata;
	pixelT                   tftColor;
	logic                    tftHSync;
	logic                    tftVSync;
	logic                    tftDe;
	logic                    tftBackLight;

	rowT  rows [numRows];
	logic tableReady;
	int   errors;
	int   checks;
	int   failedRows;

	videoTxUnit UUT (
		.sClk         (sClk),
		.videoClk     (videoClk),
		.rstN         (rstN),
		.apbReq       (apbReq),
		.prdata       (prdata),
		.tftColor     (tftColor),
		.tftHSync     (tftHSync),
		.tftVSync     (tftVSync),
		.tftDe        (tftDe),
		.tftBackLight (tftBackLight)
	);

	initial
	begin
		sClk = 1'b0;
		forever #sClkHalf sClk = ~sClk;
	end

	initial
	begin
		videoClk = 1'b0;
		forever #videoClkHalf videoClk = ~videoClk;
	end

	// ---------------------------------------------------------------------
	// Compare tasks
	// ---------------------------------------------------------------------
	task automatic checkPixel(input string name, input pixelT got, input pixelT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkData(input string name, input logic [apbDataWidth-1:0] got,
		input logic [apbDataWidth-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// ---------------------------------------------------------------------
	// APB access, zero wait
	// ---------------------------------------------------------------------
	task automatic apbWrite(input logic [apbAddrWidth-1:0] addr,
		input logic [apbDataWidth-1:0] data);
		@(posedge sClk);
		#1;
		apbReq.paddr   = addr;
		apbReq.pwdata  = data;
		apbReq.pwrite  = 1'b1;
		apbReq.psel    = 1'b1;
		apbReq.penable = 1'b0;
		@(posedge sClk);
		#1;
		apbReq.penable = 1'b1;
		// Register takes the value on this edge
		@(posedge sClk);
		#1;
		apbReq = '0;
	endtask

	task automatic apbRead(input logic [apbAddrWidth-1:0] addr,
		output logic [apbDataWidth-1:0] data);
		@(posedge sClk);
		#1;
		apbReq.paddr   = addr;
		apbReq.pwrite  = 1'b0;
		apbReq.psel    = 1'b1;
		apbReq.penable = 1'b0;
		@(posedge sClk);
		#1;
		apbReq.penable = 1'b1;
		// Mid access phase, prdata settled
		@(negedge sClk);
		data = prdata;
		@(posedge sClk);
		#1;
		apbReq = '0;
	endtask

	// ---------------------------------------------------------------------
	// Table
	// ---------------------------------------------------------------------
	task automatic setRow(input int idx, input int hd, input int hss, input int hse,
		input int hm, input int vd, input int vss, input int vse, input int vm,
		input int ca, input int cb, input int duty, input bit rnd);
		rows[idx].cfg.hDisplay   = hWidth'(hd);
		rows[idx].cfg.hSyncStart = hWidth'(hss);
		rows[idx].cfg.hSyncEnd   = hWidth'(hse);
		rows[idx].cfg.hMax       = hWidth'(hm);
		rows[idx].cfg.vDisplay   = vWidth'(vd);
		rows[idx].cfg.vSyncStart = vWidth'(vss);
		rows[idx].cfg.vSyncEnd   = vWidth'(vse);
		rows[idx].cfg.vMax       = vWidth'(vm);
		rows[idx].colorA         = pixelT'(pixelBits'(ca));
		rows[idx].colorB         = pixelT'(pixelBits'(cb));
		rows[idx].blDuty         = 8'(duty);
		rows[idx].randColors     = rnd;
	endtask

	task automatic fillTable();
		// About 40x20 active with a few lines of blanking
		setRow(0, 40, 44, 50, 56, 20, 22, 24, 26, 'hf00, 'h0f0, 64, 1'b0);
		setRow(1, 40, 42, 46, 52, 20, 21, 23, 25, 0, 0, 200, 1'b1);
		setRow(2, 36, 38, 42, 48, 18, 19, 21, 23, 0, 0, 5, 1'b1);
	endtask

	function automatic int frameNs(input rowT r);
		return int'(r.cfg.hMax) * int'(r.cfg.vMax) * 2 * videoClkHalf;
	endfunction

	// Write data for register words 0 to 10
	function automatic logic [apbDataWidth-1:0] regValue(input rowT r, input int idx);
		logic [apbDataWidth-1:0] v;
		case (idx)
			0:       v = apbDataWidth'(r.cfg.hDisplay);
			1:       v = apbDataWidth'(r.cfg.hSyncStart);
			2:       v = apbDataWidth'(r.cfg.hSyncEnd);
			3:       v = apbDataWidth'(r.cfg.hMax);
			4:       v = apbDataWidth'(r.cfg.vDisplay);
			5:       v = apbDataWidth'(r.cfg.vSyncStart);
			6:       v = apbDataWidth'(r.cfg.vSyncEnd);
			7:       v = apbDataWidth'(r.cfg.vMax);
			8:       v = apbDataWidth'(r.colorA);
			9:       v = apbDataWidth'(r.colorB);
			default: v = apbDataWidth'(r.blDuty);
		endcase
		return v;
	endfunction

	// ---------------------------------------------------------------------
	// Checkers
	// ---------------------------------------------------------------------
	task automatic writeConfig(input rowT r);
		logic [apbDataWidth-1:0] rd;
		for (int i = 0; i <= 10; i++)
			apbWrite(apbAddrWidth'(i), regValue(r, i));
		for (int i = 0; i <= 10; i++)
		begin
			apbRead(apbAddrWidth'(i), rd);
			checkData($sformatf("prdata word %0d", i), rd, regValue(r, i));
		end
		// Holes in the map
		apbRead(apbAddrWidth'(13), rd);
		checkData("prdata word 13", rd, '0);
		apbRead(apbAddrWidth'(63), rd);
		checkData("prdata word 63", rd, '0);
	endtask

	task automatic checkBackLight(input logic [7:0] duty);
		int high;
		high = 0;
		repeat (2) @(posedge sClk);
		// Any 256 cycle window holds one full period
		repeat (256)
		begin
			@(negedge sClk);
			if (tftBackLight)
				high++;
		end
		checkCount("tftBackLight high cycles", high, int'(duty));
	endtask

	// Follows the raster from enable through two active frames
	task automatic checkRaster(input rowT r, output int vsCount);
		int    cyc;
		int    x;
		int    y;
		int    frames;
		int    hsRun;
		int    lastHsRise;
		logic  prevDe;
		logic  prevHs;
		logic  prevVs;
		pixelT exp;
		cyc        = 0;
		x          = 0;
		y          = 0;
		frames     = 0;
		hsRun      = 0;
		lastHsRise = -1;
		vsCount    = 0;
		prevDe     = 1'b0;
		prevHs     = 1'b0;
		prevVs     = 1'b0;
		while (frames < 2)
		begin
			@(negedge videoClk);
			cyc++;
			if (tftHSync && !prevHs)
			begin
				if (lastHsRise >= 0)
					checkCount("tftHSync period", cyc - lastHsRise, int'(r.cfg.hMax));
				lastHsRise = cyc;
				hsRun = 0;
			end
			if (tftHSync)
				hsRun++;
			if (!tftHSync && prevHs && lastHsRise >= 0)
				checkCount("tftHSync width", hsRun,
					int'(r.cfg.hSyncEnd) - int'(r.cfg.hSyncStart));
			// Each later vSync closes a frame of active lines
			if (tftVSync && !prevVs)
			begin
				vsCount++;
				if (vsCount > 1)
					checkCount("tftDe lines", y, int'(r.cfg.vDisplay));
				y = 0;
			end
			if (tftDe)
			begin
				// Tile bit of x against tile bit of y
				if ((((x >> mapChipBs) ^ (y >> mapChipBs)) & 1) != 0)
					exp = r.colorB;
				else
					exp = r.colorA;
				checkPixel("tftColor", tftColor, exp);
				x++;
			end
			else if (prevDe)
			begin
				checkCount("tftDe length", x, int'(r.cfg.hDisplay));
				x = 0;
				y++;
				if (y == int'(r.cfg.vDisplay))
					frames++;
			end
			prevDe = tftDe;
			prevHs = tftHSync;
			prevVs = tftVSync;
		end
	endtask

	task automatic runRow(input int idx);
		rowT                     r;
		int                      errBefore;
		int                      vsCount;
		logic [apbDataWidth-1:0] rd;
		r = rows[idx];
		errBefore = errors;
		if (r.randColors)
		begin
			r.colorA = pixelT'(pixelBits'($urandom));
			r.colorB = pixelT'(pixelBits'($urandom));
			if (r.colorA == r.colorB)
				r.colorB = ~r.colorA;
		end
		// Off, then time for the FIFO to drain
		apbWrite(regCtrl, '0);
		repeat (100) @(posedge sClk);
		writeConfig(r);
		checkBackLight(r.blDuty);
		apbWrite(regCtrl, apbDataWidth'(1));
		apbRead(regStatus, rd);
		checkData("regStatus after enable", rd, '0);
		apbRead(regCtrl, rd);
		checkData("regCtrl", rd, apbDataWidth'(1));
		checkRaster(r, vsCount);
		// Still in blanking, before the next vSync
		apbRead(regStatus, rd);
		checkCount("tftVSync pulses", vsCount, 2);
		checkData("regStatus", rd, {8'd2, 8'h00});
		if (errors == errBefore)
			$display("row %0d: pass", idx);
		else
		begin
			failedRows++;
			$display("row %0d: %0d errors", idx, errors - errBefore);
		end
	endtask

	// ---------------------------------------------------------------------
	// Main sequence and watchdog
	// ---------------------------------------------------------------------
	initial
	begin
		rstN       = 1'b0;
		apbReq     = '0;
		errors     = 0;
		checks     = 0;
		failedRows = 0;
		tableReady = 1'b0;
		void'($urandom(57033));
		fillTable();
		tableReady = 1'b1;
		repeat (10) @(posedge sClk);
		#1;
		rstN = 1'b1;
		for (int i = 0; i < numRows; i++)
			runRow(i);
		$display("rows %0d, rows failed %0d, checks %0d, errors %0d",
			numRows, failedRows, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial
	begin
		longint limitNs;
		wait (tableReady === 1'b1);
		// Two checked frames per row, doubled for setup and lead-in blanking
		limitNs = 20000;
		for (int i = 0; i < numRows; i++)
			limitNs += 4 * frameNs(rows[i]);
		#(limitNs);
		$display("watchdog: run did not finish within %0d ns", limitNs);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
videoPkg.sv
videoCsrApb.sv
videoPixelGen.sv
videoDualClkFifo.sv
videoSyncGen.sv
dutyGenerator.sv
videoTxUnit.sv
tbVideoTxUnit.sv

// File: run.sh
#!/bin/sh
# Build and run the video transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tbVideoTxUnit -o simTb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/simTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" sim.log; then
	exit 0
fi
exit 1
